// File: verilog/waveform_pkg.sv
// shared types and constants for the waveform generator
// spi frame field types, command codes, frame length
// playback sample type and the waveform word union

package waveform_pkg;

	// -----------------------------------------------
	// spi frame fields
	// -----------------------------------------------

	// command byte, sent first in every frame
	typedef logic [7:0] command_t;

	// only this command writes; anything else is a read
	localparam command_t CMD_WRITE = 8'h01;

	typedef logic [15:0] spi_address_t;
	typedef logic [31:0] spi_word_t;

	// command8 + address16 + data32
	localparam int FRAME_BITS = 56;

	// -----------------------------------------------
	// playback
	// -----------------------------------------------

	typedef logic [7:0] sample_t;

	// one stored word, seen whole by spi or as byte lanes by playback
	// lane 3 is the byte that arrives first over spi and plays first
	typedef union packed {
		spi_word_t word;
		sample_t [3:0] lanes;
	} wave_word_u;

endpackage

// File: verilog/spi_command_slave.sv
// spi slave for command8 / address16 / data32 frames
// sck, mosi and ssel oversampled in word_clock
// address presented after 24 bits, read word shifted out on miso

`timescale 1ns/1ps

module spi_command_slave #(
	parameter int oversample_guard = 4
) (
	input logic word_clock,
	input logic reset3_word_clock,
	input logic sck,
	input logic mosi,
	input logic ssel,
	input waveform_pkg::spi_word_t read_data,
	output logic miso,
	output logic transaction_valid,
	output logic address_ready,
	output waveform_pkg::command_t command,
	output waveform_pkg::spi_address_t address,
	output waveform_pkg::spi_word_t data
);
	import waveform_pkg::*;

	// two sync stages plus the edge detect
	localparam int edge_latency = 3;
	localparam int count_width = $clog2(FRAME_BITS + 1);
	localparam int address_bits = $bits(command_t) + $bits(spi_address_t);
	localparam int word_bits = $bits(spi_word_t);

	logic [1:0] sck_pipe;
	logic [1:0] mosi_pipe;
	logic [1:0] ssel_pipe;
	logic sck_last;
	logic ssel_last;
	logic sck_rise;
	logic sck_fall;
	logic ssel_rise;
	logic data_phase;
	logic [count_width-1:0] bit_count;
	spi_word_t frame_shift;
	spi_word_t miso_shift;

	// sck half period has to outlast the edge latency
	if (oversample_guard <= edge_latency) begin : guard_check
		$error("oversample_guard too small for the sck edge latency");
	end

	// -----------------------------------------------
	// input synchronizers and edge detect
	// -----------------------------------------------
	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			sck_pipe <= '0;
			mosi_pipe <= '0;
			ssel_pipe <= '1;
			sck_last <= 1'b0;
			ssel_last <= 1'b1;
		end else begin
			sck_pipe <= {sck_pipe[0], sck};
			mosi_pipe <= {mosi_pipe[0], mosi};
			ssel_pipe <= {ssel_pipe[0], ssel};
			sck_last <= sck_pipe[1];
			ssel_last <= ssel_pipe[1];
		end
	end

	assign sck_rise = sck_pipe[1] & ~sck_last;
	assign sck_fall = ~sck_pipe[1] & sck_last;
	assign ssel_rise = ssel_pipe[1] & ~ssel_last;
	assign data_phase = (bit_count >= count_width'(address_bits))
		&& (bit_count < count_width'(FRAME_BITS));

	// -----------------------------------------------
	// bit counter and frame strobes
	// -----------------------------------------------
	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			bit_count <= '0;
			transaction_valid <= 1'b0;
			address_ready <= 1'b0;
		end else begin
			// a frame counts only with exactly FRAME_BITS clocks
			transaction_valid <= ssel_rise && (bit_count == count_width'(FRAME_BITS));
			address_ready <= 1'b0;
			if (ssel_pipe[1]) begin
				bit_count <= '0;
			end else if (sck_rise) begin
				// saturate so long frames never alias to a valid length
				if (bit_count != '1) begin
					bit_count <= bit_count + 1'b1;
				end
				address_ready <= (bit_count == count_width'(address_bits - 1));
			end
		end
	end

	// mosi sampled on rising sck, msb first
	always_ff @(posedge word_clock) begin
		if (!ssel_pipe[1] && sck_rise) begin
			frame_shift <= {frame_shift[word_bits-2:0], mosi_pipe[1]};
			if (bit_count == count_width'(address_bits - 1)) begin
				{command, address} <= {frame_shift[address_bits-2:0], mosi_pipe[1]};
			end
		end
		if (ssel_rise) begin
			data <= frame_shift;
		end
	end

	// -----------------------------------------------
	// read word back to the master
	// -----------------------------------------------
	always_ff @(posedge word_clock) begin
		if (address_ready) begin
			miso_shift <= read_data;
		end else if (sck_fall && data_phase) begin
			miso_shift <= {miso_shift[word_bits-2:0], 1'b0};
		end
	end

	// miso moves after falling sck, master samples on the rise
	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			miso <= 1'b0;
		end else if (ssel_pipe[1]) begin
			miso <= 1'b0;
		end else if (sck_fall && data_phase) begin
			miso <= miso_shift[word_bits-1];
		end
	end

endmodule

// File: verilog/control_registers.sv
// control register bank, four 32-bit words
// register 0 holds the playback start byte address
// register 1 holds the playback end byte address

`timescale 1ns/1ps

module control_registers #(
	parameter int word_addr_width = 12
) (
	input logic word_clock,
	input logic reset3_word_clock,
	input logic write,
	input waveform_pkg::spi_address_t address,
	input waveform_pkg::spi_word_t data,
	output waveform_pkg::spi_word_t read_data,
	output logic [word_addr_width+1:0] start_address,
	// one bit wider so the full-memory end fits
	output logic [word_addr_width+2:0] end_address
);
	import waveform_pkg::*;

	// end of memory in bytes, four per word
	localparam spi_word_t full_end = spi_word_t'(1) << (word_addr_width + 2);

	spi_word_t registers [4];
	logic [1:0] select;

	assign select = address[1:0];

	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			registers[0] <= '0;
			registers[1] <= full_end;
			registers[2] <= '0;
			registers[3] <= '0;
		end else if (write) begin
			registers[select] <= data;
		end
	end

	assign read_data = registers[select];

	// playback limits are plain levels
	assign start_address = registers[0][word_addr_width+1:0];
	assign end_address = registers[1][word_addr_width+2:0];

endmodule

// File: verilog/waveform_memory.sv
// waveform memory, one storage array of 32-bit words
// spi port writes a whole word and reads it back combinationally
// playback port picks one byte lane per cycle, registered

`timescale 1ns/1ps

module waveform_memory #(
	parameter int word_addr_width = 12
) (
	input logic word_clock,
	input logic reset3_word_clock,
	input logic write,
	input waveform_pkg::spi_address_t write_address,
	input waveform_pkg::spi_word_t write_data,
	input logic [word_addr_width+1:0] play_address,
	output waveform_pkg::spi_word_t read_data,
	output waveform_pkg::sample_t sample
);
	import waveform_pkg::*;

	localparam int depth = 1 << word_addr_width;

	wave_word_u storage [depth];
	logic [word_addr_width-1:0] spi_index;
	logic [word_addr_width-1:0] play_index;
	logic [1:0] lane_index;
	wave_word_u play_word;

	// -----------------------------------------------
	// spi side, whole words
	// -----------------------------------------------
	assign spi_index = write_address[word_addr_width-1:0];

	always_ff @(posedge word_clock) begin
		if (write) begin
			storage[spi_index].word <= write_data;
		end
	end

	assign read_data = storage[spi_index].word;

	// -----------------------------------------------
	// playback side, byte lanes
	// -----------------------------------------------
	assign play_index = play_address[word_addr_width+1:2];
	assign play_word = storage[play_index];

	// byte 0 of a word is lane 3, the first one over spi
	assign lane_index = 2'd3 - play_address[1:0];

	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			sample <= '0;
		end else begin
			sample <= play_word.lanes[lane_index];
		end
	end

endmodule

// File: verilog/playback_sequencer.sv
// looping byte address generator for playback
// limits latched at reset and at every wrap
// sync marks the first sample of each period

`timescale 1ns/1ps

module playback_sequencer #(
	parameter int word_addr_width = 12
) (
	input logic word_clock,
	input logic reset3_word_clock,
	input logic [word_addr_width+1:0] start_address,
	input logic [word_addr_width+2:0] end_address,
	output logic [word_addr_width+1:0] play_address,
	output logic sync
);
	localparam int byte_addr_width = word_addr_width + 2;

	// latched end minus one, and whether the range is non-empty
	logic [byte_addr_width:0] last_address;
	logic running;
	logic wrap;
	// play_address sits on start after a real period end
	logic first_byte;

	// empty range reloads start every cycle
	assign wrap = !running || ({1'b0, play_address} == last_address);

	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			play_address <= start_address;
			last_address <= end_address - 1'b1;
			running <= end_address > {1'b0, start_address};
			first_byte <= 1'b0;
			sync <= 1'b0;
		end else begin
			// one more stage to line up with the registered sample
			sync <= first_byte;
			first_byte <= 1'b0;
			if (wrap) begin
				play_address <= start_address;
				last_address <= end_address - 1'b1;
				running <= end_address > {1'b0, start_address};
				// no period markers while the range is empty
				first_byte <= running;
			end else begin
				play_address <= play_address + 1'b1;
			end
		end
	end

endmodule

// File: verilog/function_generator_top.sv
// top level of the spi-programmable waveform generator
// ce0 slave drives the control registers, ce1 slave the memory
// sequencer plays the memory bytes out on sample with sync

`timescale 1ns/1ps

module function_generator_top #(
	parameter int word_addr_width = 12,
	parameter int oversample_guard = 4
) (
	input logic word_clock,
	input logic reset3_word_clock,
	input logic sck,
	input logic mosi,
	input logic ce0,
	input logic ce1,
	output logic miso,
	output waveform_pkg::sample_t sample,
	output logic sync
);
	import waveform_pkg::*;

	localparam int byte_addr_width = word_addr_width + 2;

	logic miso_ce0;
	logic miso_ce1;
	logic transaction_valid_ce0;
	logic transaction_valid_ce1;
	command_t command_ce0;
	command_t command_ce1;
	spi_address_t address_ce0;
	spi_address_t address_ce1;
	spi_word_t data_ce0;
	spi_word_t data_ce1;
	spi_word_t read_data_ce0;
	spi_word_t read_data_ce1;
	logic write_registers;
	logic write_memory;
	logic [byte_addr_width-1:0] start_address;
	logic [byte_addr_width:0] end_address;
	logic [byte_addr_width-1:0] play_address;

	// selected slave drives miso
	assign miso = ce0 ? miso_ce1 : miso_ce0;

	assign write_registers = transaction_valid_ce0 && (command_ce0 == CMD_WRITE);
	assign write_memory = transaction_valid_ce1 && (command_ce1 == CMD_WRITE);

	// -----------------------------------------------
	// control path
	// -----------------------------------------------
	spi_command_slave #(.oversample_guard(oversample_guard)) spi_ce0 (
		.word_clock(word_clock), .reset3_word_clock(reset3_word_clock),
		.sck(sck), .mosi(mosi), .ssel(ce0), .read_data(read_data_ce0),
		.miso(miso_ce0), .transaction_valid(transaction_valid_ce0), .address_ready(),
		.command(command_ce0), .address(address_ce0), .data(data_ce0));

	control_registers #(.word_addr_width(word_addr_width)) registers (
		.word_clock(word_clock), .reset3_word_clock(reset3_word_clock),
		.write(write_registers), .address(address_ce0), .data(data_ce0),
		.read_data(read_data_ce0), .start_address(start_address), .end_address(end_address));

	spi_command_slave #(.oversample_guard(oversample_guard)) spi_ce1 (
		.word_clock(word_clock), .reset3_word_clock(reset3_word_clock),
		.sck(sck), .mosi(mosi), .ssel(ce1), .read_data(read_data_ce1),
		.miso(miso_ce1), .transaction_valid(transaction_valid_ce1), .address_ready(),
		.command(command_ce1), .address(address_ce1), .data(data_ce1));

	// -----------------------------------------------
	// playback path
	// -----------------------------------------------
	waveform_memory #(.word_addr_width(word_addr_width)) memory (
		.word_clock(word_clock), .reset3_word_clock(reset3_word_clock),
		.write(write_memory), .write_address(address_ce1), .write_data(data_ce1),
		.play_address(play_address), .read_data(read_data_ce1), .sample(sample));

	playback_sequencer #(.word_addr_width(word_addr_width)) sequencer (
		.word_clock(word_clock), .reset3_word_clock(reset3_word_clock),
		.start_address(start_address), .end_address(end_address),
		.play_address(play_address), .sync(sync));

endmodule

// File: testbench/function_generator_props.sv
// assertions on the playback sequencer, bound in
// sync width, address range, sync in reset

`timescale 1ns/1ps

module function_generator_props #(
	parameter int word_addr_width = 12
) (
	input logic word_clock,
	input logic reset3_word_clock,
	input logic [word_addr_width+1:0] play_address,
	input logic [word_addr_width+2:0] last_address,
	input logic running,
	input logic sync
);

	// number of failed properties so far
	int failures = 0;

	// one cycle wide
	sync_single: assert property (@(posedge word_clock) disable iff (reset3_word_clock)
		sync |=> !sync)
		else begin
			failures++;
			$error("sync high for two cycles");
		end

	// latched end minus one bounds the address
	address_range: assert property (@(posedge word_clock) disable iff (reset3_word_clock)
		running |-> ({1'b0, play_address} <= last_address))
		else begin
			failures++;
			$error("play_address beyond the end address");
		end

	sync_in_reset: assert property (@(posedge word_clock)
		reset3_word_clock |=> !sync)
		else begin
			failures++;
			$error("sync high after a reset cycle");
		end

endmodule

bind playback_sequencer function_generator_props #(.word_addr_width(word_addr_width)) props (
	.word_clock(word_clock), .reset3_word_clock(reset3_word_clock),
	.play_address(play_address), .last_address(last_address),
	.running(running), .sync(sync));

// File: testbench/function_generator_tb.sv
// testbench for the spi waveform generator
// spi master tasks, golden file reader, memory model
// readback checks and playback period checks

`timescale 1ns/1ps

module function_generator_tb;
	import waveform_pkg::*;

	localparam int word_addr_width = 6;
	localparam int words = 1 << word_addr_width;
	localparam int half_period = 5;
	localparam int max_int = 32'h7fffffff;
	localparam command_t cmd_read = 8'h00;
	localparam command_t cmd_other = 8'h02;
	// ce release to the first sync whose period uses the new limits
	// three to the strobe, one to the register write, two from wrap to sync
	localparam int limit_delay = 6;

	logic word_clock = 1'b0;
	logic reset3_word_clock;
	logic sck;
	logic mosi;
	logic ce0;
	logic ce1;
	logic miso;
	sample_t sample;
	logic sync;

	// mirror of every memory write
	spi_word_t model [words];
	int cycle_count = 0;
	// cycles since the last sync, equals the byte offset in the period
	int phase_count = 0;
	int release_cycle = 0;

	function_generator_top #(.word_addr_width(word_addr_width)) DUT (
		.word_clock(word_clock), .reset3_word_clock(reset3_word_clock),
		.sck(sck), .mosi(mosi), .ce0(ce0), .ce1(ce1),
		.miso(miso), .sample(sample), .sync(sync));

	always #2 word_clock = ~word_clock;

	always @(posedge word_clock) begin
		cycle_count <= cycle_count + 1;
		phase_count <= sync ? 1 : phase_count + 1;
	end

	// -----------------------------------------------
	// reporting and compare tasks
	// -----------------------------------------------
	task automatic fail_run(input string what);
		$display("%s", what);
		$display("TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input spi_word_t got, input spi_word_t expected, input string name);
		if (got !== expected) begin
			fail_run($sformatf("Fail %s got %h expected %h", name, got, expected));
		end
	endtask

	task automatic check_sample(input sample_t got, input sample_t expected, input string name);
		if (got !== expected) begin
			fail_run($sformatf("Fail %s got %h expected %h", name, got, expected));
		end
	endtask

	task automatic check_flag(input logic got, input logic expected, input string name);
		if (got !== expected) begin
			fail_run($sformatf("Fail %s got %h expected %h", name, got, expected));
		end
	endtask

	// byte k of the stream, lane 3 first within a word
	function automatic sample_t model_byte(input int byte_address);
		spi_word_t w;
		w = model[(byte_address >> 2) % words];
		return sample_t'(w >> (8 * (3 - byte_address % 4)));
	endfunction

	// -----------------------------------------------
	// spi master
	// -----------------------------------------------
	task automatic transfer_frame(input logic chip, input command_t cmd,
			input spi_address_t addr, input spi_word_t wdata, input int bits,
			output spi_word_t rdata);
		logic [FRAME_BITS-1:0] frame;
		frame = {cmd, addr, wdata};
		rdata = '0;
		@(negedge word_clock);
		if (chip) begin
			ce1 = 1'b0;
		end else begin
			ce0 = 1'b0;
		end
		for (int i = 0; i < bits; i++) begin
			mosi = frame[FRAME_BITS-1-i];
			repeat (half_period) @(negedge word_clock);
			// read word comes back during the data phase
			if (i >= FRAME_BITS - $bits(spi_word_t)) begin
				rdata = {rdata[30:0], miso};
			end
			sck = 1'b1;
			repeat (half_period) @(negedge word_clock);
			sck = 1'b0;
		end
		repeat (half_period) @(negedge word_clock);
		ce0 = 1'b1;
		ce1 = 1'b1;
		mosi = 1'b0;
		release_cycle = cycle_count;
		repeat (6 + $urandom % 6) @(negedge word_clock);
	endtask

	// -----------------------------------------------
	// playback checks
	// -----------------------------------------------
	task automatic wait_sync(input int limit);
		int n;
		n = 0;
		do begin
			@(negedge word_clock);
			n++;
			if (n > limit) begin
				fail_run("timeout while waiting for a sync pulse");
			end
		end while (sync !== 1'b1);
	endtask

	// starts on a negedge where sync is high
	task automatic check_periods(input int start, input int len, input int periods);
		for (int p = 0; p < periods; p++) begin
			for (int k = 0; k < len; k++) begin
				check_flag(sync, k == 0, "sync");
				check_sample(sample, model_byte(start + k), "sample");
				@(negedge word_clock);
			end
		end
		check_flag(sync, 1'b1, "sync");
	endtask

	// end limit changes while playing, old length holds until the next wrap
	task automatic watch_end_change(input int start, input int old_len, input int new_len,
			input int periods);
		int prev;
		int seen;
		int idle;
		prev = -1;
		seen = 0;
		idle = 0;
		while (seen < periods) begin
			@(negedge word_clock);
			idle++;
			if (idle > 4 * new_len + 20) begin
				fail_run("timeout while waiting for a sync pulse");
			end
			if (sync) begin
				if (prev >= 0) begin
					if (prev - release_cycle < limit_delay) begin
						check_word(phase_count, old_len, "sync_spacing");
					end else begin
						check_word(phase_count, new_len, "sync_spacing");
						seen++;
					end
				end
				check_sample(sample, model_byte(start), "sample");
				prev = cycle_count;
				idle = 0;
			end else if (prev >= 0) begin
				if (phase_count >= new_len) begin
					fail_run("playback ran past the end address");
				end
				check_sample(sample, model_byte(start + phase_count), "sample");
			end
		end
	endtask

	// -----------------------------------------------
	// main sequence
	// -----------------------------------------------
	initial begin
		int fd;
		int code;
		string line;
		byte kind;
		spi_word_t f1;
		spi_word_t f2;
		spi_word_t f3;
		spi_word_t rdata;
		int cur_start;
		int cur_len;
		int limit;
		void'($urandom(32'h9750));
		reset3_word_clock = 1'b1;
		sck = 1'b0;
		mosi = 1'b0;
		ce0 = 1'b1;
		ce1 = 1'b1;
		cur_start = 0;
		cur_len = 4 * words;
		repeat (16) @(negedge word_clock);
		reset3_word_clock = 1'b0;

		fd = $fopen("testbench/function_generator_golden.txt", "r");
		if (fd == 0) begin
			fail_run("could not open the golden file");
		end
		while (!$feof(fd)) begin
			line = "";
			code = $fgets(line, fd);
			if (code == 0 || line.len() < 2 || line[0] == "#") begin
				continue;
			end
			code = $sscanf(line, "%c %h %h %h", kind, f1, f2, f3);
			case (kind)
				"W": begin
					transfer_frame(1'b1, CMD_WRITE, f1[15:0], f2, FRAME_BITS, rdata);
					model[f1 % words] = f2;
				end
				"X": transfer_frame(1'b1, cmd_other, f1[15:0], f2, FRAME_BITS, rdata);
				// ssel rises after 40 bits
				"A": transfer_frame(1'b1, CMD_WRITE, f1[15:0], f2, 40, rdata);
				"R": transfer_frame(1'b0, CMD_WRITE, f1[15:0], f2, FRAME_BITS, rdata);
				"M": begin
					transfer_frame(1'b1, cmd_read, f1[15:0], '0, FRAME_BITS, rdata);
					check_word(rdata, f2, "miso_ce1");
				end
				"G": begin
					transfer_frame(1'b0, cmd_read, f1[15:0], '0, FRAME_BITS, rdata);
					check_word(rdata, f2, "miso_ce0");
				end
				"P": begin
					transfer_frame(1'b0, CMD_WRITE, 16'd0, f1, FRAME_BITS, rdata);
					transfer_frame(1'b0, CMD_WRITE, 16'd1, f2, FRAME_BITS, rdata);
					limit = 4 * ((cur_len > int'(f2 - f1)) ? cur_len : int'(f2 - f1)) + 20;
					wait_sync(limit);
					wait_sync(limit);
					check_periods(int'(f1), int'(f2 - f1), int'(f3));
					cur_start = int'(f1);
					cur_len = int'(f2 - f1);
				end
				"C": begin
					release_cycle = max_int;
					fork
						transfer_frame(1'b0, CMD_WRITE, 16'd1, f2, FRAME_BITS, rdata);
						watch_end_change(cur_start, cur_len, int'(f2 - f1), int'(f3));
					join
					cur_len = int'(f2 - f1);
				end
				default: fail_run("unknown record type in the golden file");
			endcase
		end
		$fclose(fd);
		if (DUT.sequencer.props.failures != 0) begin
			fail_run("a playback sequencer assertion failed");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

// File: testbench/function_generator_golden.txt
# columns: type, address or start (hex), word or end (hex), periods (hex)
# W/X/A memory frames, R register write, M/G readback, P/C playback limits
G 0000 00000000 0
G 0001 00000100 0
W 0000 00112233 0
W 0001 44556677 0
W 0002 8899aabb 0
W 0003 ccddeeff 0
W 0004 0f1e2d3c 0
W 0005 4b5a6978 0
W 0006 8796a5b4 0
W 0007 c3d2e1f0 0
W 0008 13579bdf 0
W 0009 2468ace0 0
W 000a fedcba98 0
W 000b 76543210 0
M 0000 00112233 0
M 0005 4b5a6978 0
M 000b 76543210 0
X 0002 ffffffff 0
M 0002 8899aabb 0
A 0003 deadbeef 0
M 0003 ccddeeff 0
P 0004 00000014 2
P 0005 0000001d 2
P 0008 00000018 3
C 0008 00000028 2
G 0000 00000008 0
G 0001 00000028 0

// File: filelist.f
verilog/waveform_pkg.sv
verilog/spi_command_slave.sv
verilog/control_registers.sv
verilog/waveform_memory.sv
verilog/playback_sequencer.sv
verilog/function_generator_top.sv
testbench/function_generator_props.sv
testbench/function_generator_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f \
	--top-module function_generator_tb \
	-Mdir obj_dir -o sim_function_generator
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_function_generator > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation returned status $run_status"
	exit 1
fi

if grep -qx "TESTS PASSED" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
